// File: Makefile
# Verilator build and run for the watchdog testbench

VERILATOR  ?= verilator
TOP        ?= wdg_tb
RTL_TOP    ?= wdg_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "no result found in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(filter design/%,$(shell cat $(FILELIST)))

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/crc8_calc.sv
/* combinational crc-8 over {marker, address, data} */
`timescale 1ns/1ps

module crc8_calc import wdg_regmap_pkg::*; (
    input  logic [REG_AW+REG_DW:0] i_data,
    output logic [CRC_W-1:0]       o_crc
);

    logic [CRC_W-1:0] crc;
    logic             fb;

    // msb first, init 0, no reflection, no final xor
    always_comb begin
        crc = '0;
        fb  = 1'b0;
        for (int i = REG_AW + REG_DW; i >= 0; i--) begin
            fb  = crc[CRC_W-1] ^ i_data[i];
            crc = {crc[CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
    end

    assign o_crc = crc;

endmodule

// File: design/reg_scan_if.sv
/* four-phase scan read channel between scan controller and register bank */
`timescale 1ns/1ps

interface reg_scan_if import wdg_regmap_pkg::*; ();

    logic              req;
    logic [REG_AW-1:0] addr;
    logic              ack;
    // valid while ack is high
    logic [REG_DW-1:0] data;
    logic [CRC_W-1:0]  crc;

    modport ctrl (
        output req, addr,
        input  ack, data, crc
    );

    modport bank (
        input  req, addr,
        output ack, data, crc
    );

endinterface

// File: design/wdg_link_ctrl.sv
/* refresh request timer, four-phase request to the one-wire tx, response timeout */
`timescale 1ns/1ps

module wdg_link_ctrl import wdg_timing_pkg::*; #(
    parameter int CYC_PER_UNIT = 48
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_link_en,
    input  wdg_period_e i_refresh_cfg,
    input  wdg_period_e i_tmo_cfg,
    output logic        o_refresh_req,
    input  logic        i_refresh_ack,
    input  logic        i_spi_wdg_rst,
    input  logic        i_rsp,
    output logic        o_timeout_err
);

    localparam int CNT_W = $clog2(MAX_PERIOD_UNITS * CYC_PER_UNIT);

    link_state_e      state;
    logic [CNT_W-1:0] ref_cnt;
    logic [CNT_W-1:0] ref_last;
    logic [CNT_W-1:0] tmo_cnt;
    logic [CNT_W-1:0] tmo_last;
    logic             ref_fire;
    logic             armed;
    logic             tmo_hit;

    assign ref_last = CNT_W'(PERIOD_UNITS[i_refresh_cfg] * CYC_PER_UNIT - 1);
    assign tmo_last = CNT_W'(PERIOD_UNITS[i_tmo_cfg] * CYC_PER_UNIT - 1);

    assign ref_fire = i_link_en && (state == LINK_WAIT) && !i_spi_wdg_rst
                      && (ref_cnt >= ref_last);

    // a response or restart on the last count still saves the link
    assign tmo_hit = i_link_en && armed && !i_spi_wdg_rst && !i_rsp
                     && (tmo_cnt >= tmo_last);

    // ======================================================================
    // refresh request
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= LINK_WAIT;
            ref_cnt       <= '0;
            o_refresh_req <= 1'b0;
        end else if (!i_link_en) begin
            ref_cnt       <= '0;
            o_refresh_req <= 1'b0;
            case (state)
                LINK_REQ:     state <= LINK_RELEASE;
                LINK_RELEASE: if (!i_refresh_ack) state <= LINK_WAIT;
                default:      state <= LINK_WAIT;
            endcase
        end else begin
            case (state)
                LINK_WAIT: begin
                    if (i_spi_wdg_rst) begin
                        ref_cnt <= '0;
                    end else if (ref_fire) begin
                        ref_cnt       <= '0;
                        o_refresh_req <= 1'b1;
                        state         <= LINK_REQ;
                    end else begin
                        ref_cnt <= ref_cnt + 1'b1;
                    end
                end
                LINK_REQ: begin
                    if (i_refresh_ack) begin
                        o_refresh_req <= 1'b0;
                        state         <= LINK_RELEASE;
                    end
                end
                LINK_RELEASE: begin
                    if (!i_refresh_ack) state <= LINK_WAIT;
                end
                default: state <= LINK_WAIT;
            endcase
        end
    end

    // ======================================================================
    // response timeout
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            armed         <= 1'b0;
            tmo_cnt       <= '0;
            o_timeout_err <= 1'b0;
        end else begin
            o_timeout_err <= tmo_hit;
            if (!i_link_en) begin
                armed   <= 1'b0;
                tmo_cnt <= '0;
            end else if (i_spi_wdg_rst) begin
                armed   <= 1'b1;
                tmo_cnt <= '0;
            end else if (tmo_hit) begin
                // a request on this edge re-arms at once
                armed   <= ref_fire;
                tmo_cnt <= '0;
            end else begin
                if (ref_fire) armed <= 1'b1;
                // rsp only restarts the count, stays armed
                tmo_cnt <= (!armed || i_rsp) ? '0 : tmo_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/wdg_reg_bank.sv
/* scanned register bank with stored crcs, host write port and scan responder */
`timescale 1ns/1ps

module wdg_reg_bank import wdg_timing_pkg::*, wdg_regmap_pkg::*; (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_wr_en,
    input  logic [REG_AW-1:0] i_wr_addr,
    input  logic [REG_DW-1:0] i_wr_data,
    input  logic [CRC_W-1:0]  i_wr_crc,
    reg_scan_if.bank          scan,
    output wdg_period_e       o_tmo_cfg,
    output wdg_period_e       o_refresh_cfg,
    output wdg_period_e       o_scan_cfg
);

    // config register sits at the end of the list
    localparam int CFG_IDX = SCAN_REG_NUM - 1;

    logic [REG_DW-1:0] reg_data [SCAN_REG_NUM];
    logic [CRC_W-1:0]  reg_crc  [SCAN_REG_NUM];
    logic [REG_DW-1:0] rd_data;
    logic [CRC_W-1:0]  rd_crc;

    // ======================================================================
    // host write
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < SCAN_REG_NUM; i++) begin
                reg_data[i] <= '0;
                reg_crc[i]  <= RESET_CRC[i];
            end
        end else begin
            // unlisted addresses fall through
            for (int i = 0; i < SCAN_REG_NUM; i++) begin
                if (i_wr_en && (i_wr_addr == SCAN_ADDR_LIST[i])) begin
                    reg_data[i] <= i_wr_data;
                    reg_crc[i]  <= i_wr_crc;
                end
            end
        end
    end

    // ======================================================================
    // scan responder
    // ======================================================================
    always_comb begin
        rd_data = '0;
        rd_crc  = '0;
        for (int i = 0; i < SCAN_REG_NUM; i++) begin
            if (scan.addr == SCAN_ADDR_LIST[i]) begin
                rd_data = reg_data[i];
                rd_crc  = reg_crc[i];
            end
        end
    end

    // ack follows req one edge later
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan.ack <= 1'b0;
        end else begin
            scan.ack <= scan.req;
        end
    end

    // snapshot taken on the edge ack rises
    always_ff @(posedge i_clk) begin
        if (scan.req && !scan.ack) begin
            scan.data <= rd_data;
            scan.crc  <= rd_crc;
        end
    end

    assign o_tmo_cfg     = wdg_period_e'(reg_data[CFG_IDX][CFG_TMO_LSB +: 2]);
    assign o_refresh_cfg = wdg_period_e'(reg_data[CFG_IDX][CFG_REFRESH_LSB +: 2]);
    assign o_scan_cfg    = wdg_period_e'(reg_data[CFG_IDX][CFG_SCAN_LSB +: 2]);

endmodule

// File: design/wdg_regmap_pkg.sv
/* register map widths, scan list, config field positions and crc constants */
package wdg_regmap_pkg;

    parameter int REG_AW       = 7;
    parameter int REG_DW       = 8;
    parameter int CRC_W        = 8;
    parameter int SCAN_REG_NUM = 8;

    // scan order, last entry holds the period config
    parameter logic [REG_AW-1:0] SCAN_ADDR_LIST [SCAN_REG_NUM] = '{
        7'h01, 7'h02, 7'h03, 7'h08, 7'h09, 7'h0A, 7'h0B, 7'h30
    };

    // 2-bit period fields inside register 0x30
    parameter int CFG_TMO_LSB     = 0;
    parameter int CFG_REFRESH_LSB = 2;
    parameter int CFG_SCAN_LSB    = 4;

    // x^8 + x^2 + x + 1
    parameter logic [CRC_W-1:0] CRC_POLY = 8'h07;

    // crc of {1'b1, addr, 8'h00} for each list entry
    parameter logic [CRC_W-1:0] RESET_CRC [SCAN_REG_NUM] = '{
        8'hA3, 8'h9C, 8'h89, 8'h1E, 8'h0B, 8'h34, 8'h21, 8'h4F
    };

endpackage

// File: design/wdg_scan_ctrl.sv
/* periodic register scan, crc check and sticky per-register fault flags */
`timescale 1ns/1ps

module wdg_scan_ctrl import wdg_timing_pkg::*, wdg_regmap_pkg::*; #(
    parameter int CYC_PER_UNIT = 48
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_scan_en,
    input  wdg_period_e             i_scan_cfg,
    input  logic                    i_wr_en,
    input  logic [REG_AW-1:0]       i_wr_addr,
    reg_scan_if.ctrl                scan,
    output logic [SCAN_REG_NUM-1:0] o_crc_err_flags
);

    localparam int CNT_W = $clog2(MAX_PERIOD_UNITS * CYC_PER_UNIT);
    localparam int PTR_W = $clog2(SCAN_REG_NUM);

    scan_state_e             state;
    logic [CNT_W-1:0]        cnt;
    logic [CNT_W-1:0]        period_last;
    logic [PTR_W-1:0]        ptr;
    logic                    scan_fire;
    logic                    scan_done;
    logic [CRC_W-1:0]        crc_calc;
    logic                    crc_bad;
    logic [SCAN_REG_NUM-1:0] set_vec;
    logic [SCAN_REG_NUM-1:0] clr_vec;

    assign period_last = CNT_W'(PERIOD_UNITS[i_scan_cfg] * CYC_PER_UNIT - 1);
    assign scan_fire   = i_scan_en && (state == SCAN_WAIT) && (cnt >= period_last);
    assign scan_done   = i_scan_en && (state == SCAN_REQ) && scan.ack;

    // ======================================================================
    // period timer and handshake
    // ======================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= SCAN_WAIT;
            cnt      <= '0;
            ptr      <= '0;
            scan.req <= 1'b0;
        end else if (!i_scan_en) begin
            cnt      <= '0;
            scan.req <= 1'b0;
            // an open handshake still has to see ack fall
            case (state)
                SCAN_REQ:     state <= SCAN_RELEASE;
                SCAN_RELEASE: if (!scan.ack) state <= SCAN_WAIT;
                default:      state <= SCAN_WAIT;
            endcase
        end else begin
            case (state)
                SCAN_WAIT: begin
                    if (scan_fire) begin
                        cnt      <= '0;
                        scan.req <= 1'b1;
                        state    <= SCAN_REQ;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                SCAN_REQ: begin
                    if (scan.ack) begin
                        scan.req <= 1'b0;
                        ptr      <= (ptr == PTR_W'(SCAN_REG_NUM - 1)) ? '0 : ptr + 1'b1;
                        state    <= SCAN_RELEASE;
                    end
                end
                SCAN_RELEASE: begin
                    if (!scan.ack) state <= SCAN_WAIT;
                end
                default: state <= SCAN_WAIT;
            endcase
        end
    end

    // address is held for the whole request
    always_ff @(posedge i_clk) begin
        if (scan_fire) begin
            scan.addr <= SCAN_ADDR_LIST[ptr];
        end
    end

    // ======================================================================
    // crc check and sticky flags
    // ======================================================================
    crc8_calc crc_i (
        .i_data ({1'b1, scan.addr, scan.data}),
        .o_crc  (crc_calc)
    );

    assign crc_bad = (crc_calc != scan.crc);

    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        for (int i = 0; i < SCAN_REG_NUM; i++) begin
            clr_vec[i] = i_wr_en && (i_wr_addr == SCAN_ADDR_LIST[i]);
        end
        if (scan_done && crc_bad) begin
            set_vec[ptr] = 1'b1;
        end
    end

    // set beats a same-edge clear
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc_err_flags <= '0;
        end else begin
            o_crc_err_flags <= (o_crc_err_flags & ~clr_vec) | set_vec;
        end
    end

endmodule

// File: design/wdg_timing_pkg.sv
/* period select codes, period unit table and the controller state encodings */
package wdg_timing_pkg;

    // ======================================================================
    // period selection
    // ======================================================================
    typedef enum logic [1:0] {
        P250  = 2'd0,
        P500  = 2'd1,
        P1000 = 2'd2,
        P2000 = 2'd3
    } wdg_period_e;

    // unit counts per code, same order as wdg_period_e
    parameter int unsigned PERIOD_UNITS [4] = '{250, 500, 1000, 2000};

    // longest period, sizes the counters
    parameter int unsigned MAX_PERIOD_UNITS = 2000;

    // ======================================================================
    // controller states
    // ======================================================================
    typedef enum logic [1:0] {
        SCAN_WAIT,
        SCAN_REQ,
        SCAN_RELEASE
    } scan_state_e;

    typedef enum logic [1:0] {
        LINK_WAIT,
        LINK_REQ,
        LINK_RELEASE
    } link_state_e;

endpackage

// File: design/wdg_top.sv
/* watchdog top: register bank, scan controller and link controller */
`timescale 1ns/1ps

module wdg_top import wdg_timing_pkg::*, wdg_regmap_pkg::*; #(
    parameter int CYC_PER_UNIT = 48
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_scan_en,
    input  logic                    i_link_en,
    input  logic                    i_wr_en,
    input  logic [REG_AW-1:0]       i_wr_addr,
    input  logic [REG_DW-1:0]       i_wr_data,
    input  logic [CRC_W-1:0]        i_wr_crc,
    output logic [SCAN_REG_NUM-1:0] o_crc_err_flags,
    output logic                    o_refresh_req,
    input  logic                    i_refresh_ack,
    input  logic                    i_rsp,
    input  logic                    i_spi_wdg_rst,
    output logic                    o_timeout_err
);

    wdg_period_e tmo_cfg;
    wdg_period_e refresh_cfg;
    wdg_period_e scan_cfg;

    reg_scan_if scan_bus ();

    wdg_reg_bank bank_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_wr_en       (i_wr_en),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .i_wr_crc      (i_wr_crc),
        .scan          (scan_bus.bank),
        .o_tmo_cfg     (tmo_cfg),
        .o_refresh_cfg (refresh_cfg),
        .o_scan_cfg    (scan_cfg)
    );

    wdg_scan_ctrl #(.CYC_PER_UNIT(CYC_PER_UNIT)) scan_ctrl_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_scan_en       (i_scan_en),
        .i_scan_cfg      (scan_cfg),
        .i_wr_en         (i_wr_en),
        .i_wr_addr       (i_wr_addr),
        .scan            (scan_bus.ctrl),
        .o_crc_err_flags (o_crc_err_flags)
    );

    wdg_link_ctrl #(.CYC_PER_UNIT(CYC_PER_UNIT)) link_ctrl_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_link_en     (i_link_en),
        .i_refresh_cfg (refresh_cfg),
        .i_tmo_cfg     (tmo_cfg),
        .o_refresh_req (o_refresh_req),
        .i_refresh_ack (i_refresh_ack),
        .i_spi_wdg_rst (i_spi_wdg_rst),
        .i_rsp         (i_rsp),
        .o_timeout_err (o_timeout_err)
    );

endmodule

// File: sim.f
design/wdg_timing_pkg.sv
design/wdg_regmap_pkg.sv
design/reg_scan_if.sv
design/crc8_calc.sv
design/wdg_reg_bank.sv
design/wdg_scan_ctrl.sv
design/wdg_link_ctrl.sv
design/wdg_top.sv
tests/wdg_tb.sv

// File: tests/wdg_tb.sv
/* watchdog testbench: clock, reset, stimulus, crc reference model, assertions */
`timescale 1ns/1ps

module wdg_tb import wdg_timing_pkg::*, wdg_regmap_pkg::*; ();

    localparam int CYC      = 1;
    localparam int PASS_CYC = SCAN_REG_NUM * (int'(PERIOD_UNITS[0]) * CYC + 8);
    // longer than the shortest refresh period
    localparam int ACK_HOLD_CYC = int'(PERIOD_UNITS[0]) * CYC + 50;
    // five scan passes, eight refresh rounds, held acks, two timeouts, disable window
    localparam int WATCHDOG_CYC = 5 * PASS_CYC + 8 * (int'(PERIOD_UNITS[0]) * CYC + 20)
                                  + 3 * ACK_HOLD_CYC
                                  + 3 * int'(PERIOD_UNITS[1]) * CYC + 5000;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_scan_en;
    logic                    i_link_en;
    logic                    i_wr_en;
    logic [REG_AW-1:0]       i_wr_addr;
    logic [REG_DW-1:0]       i_wr_data;
    logic [CRC_W-1:0]        i_wr_crc;
    logic [SCAN_REG_NUM-1:0] o_crc_err_flags;
    logic                    o_refresh_req;
    logic                    i_refresh_ack;
    logic                    i_rsp;
    logic                    i_spi_wdg_rst;
    logic                    o_timeout_err;

    int          value_errs = 0;
    int          proto_errs = 0;
    int          scan_count = 0;
    int          scan_idx = 0;
    int          refresh_count = 0;
    string       test_name = "reset";
    logic        rsp_mode = 1'b0;
    logic        scan_req_q = 1'b0;
    logic        reg_bad [SCAN_REG_NUM];

    wdg_top #(.CYC_PER_UNIT(CYC)) dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ======================================================================
    // reference model
    // ======================================================================
    // byte-wise, msb first, init 0
    function automatic logic [7:0] ref_crc8(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] bytes [2];
        logic [7:0] c;
        bytes[0] = {1'b1, addr};
        bytes[1] = data;
        c = 8'h00;
        for (int b = 0; b < 2; b++) begin
            c = c ^ bytes[b];
            for (int k = 0; k < 8; k++) begin
                c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] cfg_word(input wdg_period_e s, input wdg_period_e r,
                                            input wdg_period_e t);
        logic [7:0] w;
        w = '0;
        w[CFG_SCAN_LSB +: 2]    = s;
        w[CFG_REFRESH_LSB +: 2] = r;
        w[CFG_TMO_LSB +: 2]     = t;
        return w;
    endfunction

    // ======================================================================
    // stimulus tasks
    // ======================================================================
    task automatic write_reg(input int idx, input logic [7:0] data, input logic good);
        logic [7:0] crc;
        crc = ref_crc8(SCAN_ADDR_LIST[idx], data);
        if (!good) crc = crc ^ 8'h5A;
        @(posedge i_clk);
        i_wr_en   <= 1'b1;
        i_wr_addr <= SCAN_ADDR_LIST[idx];
        i_wr_data <= data;
        i_wr_crc  <= crc;
        @(posedge i_clk);
        i_wr_en <= 1'b0;
        reg_bad[idx] = !good;
    endtask

    // n new requests, then the last handshake fully closed
    task automatic wait_reads(input int n);
        int target;
        target = scan_count + n;
        @(negedge i_clk);
        while (scan_count < target || dut_i.scan_bus.req || dut_i.scan_bus.ack) begin
            @(negedge i_clk);
        end
    endtask

    task automatic check_flags();
        logic [SCAN_REG_NUM-1:0] exp;
        for (int i = 0; i < SCAN_REG_NUM; i++) exp[i] = reg_bad[i];
        @(negedge i_clk);
        assert (o_crc_err_flags == exp) else begin
            $display("[FAIL] %s: flags expected=%b actual=%b", test_name, exp, o_crc_err_flags);
            value_errs++;
        end
    endtask

    task automatic check_timeout(input wdg_period_e tmo);
        int n;
        int expected;
        expected = int'(PERIOD_UNITS[tmo]) * CYC + 1;
        n = 0;
        @(negedge i_clk);
        while (o_refresh_req || i_refresh_ack) @(negedge i_clk);
        @(posedge i_clk);
        i_spi_wdg_rst <= 1'b1;
        do begin
            @(posedge i_clk);
            i_spi_wdg_rst <= 1'b0;
            n++;
            @(negedge i_clk);
        end while (!o_timeout_err && n < 4 * expected);
        assert (n == expected) else begin
            $display("[FAIL] %s: cycles expected=%0d actual=%0d", test_name, expected, n);
            value_errs++;
        end
        @(negedge i_clk);
        assert (!o_timeout_err) else begin
            $display("[FAIL] %s: pulse end expected=0 actual=%b", test_name, o_timeout_err);
            value_errs++;
        end
    endtask

    // ======================================================================
    // monitors and assertions
    // ======================================================================
    // scan order, one check per request rise
    always @(posedge i_clk) begin
        if (i_rst_n && dut_i.scan_bus.req && !scan_req_q) begin
            assert (dut_i.scan_bus.addr == SCAN_ADDR_LIST[scan_idx]) else begin
                $display("[FAIL] %s: scan addr expected=%h actual=%h", test_name,
                         SCAN_ADDR_LIST[scan_idx], dut_i.scan_bus.addr);
                value_errs++;
            end
            scan_idx   <= (scan_idx + 1) % SCAN_REG_NUM;
            scan_count <= scan_count + 1;
        end
        scan_req_q <= dut_i.scan_bus.req;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_refresh_req && !i_refresh_ack && i_link_en) |=> o_refresh_req)
    else begin
        $display("[FAIL] %s: refresh hold expected=1 actual=%b", test_name, o_refresh_req);
        proto_errs++;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_refresh_req && i_refresh_ack) |=> !o_refresh_req)
    else begin
        $display("[FAIL] %s: refresh drop expected=0 actual=%b", test_name, o_refresh_req);
        proto_errs++;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_refresh_req) |-> !$past(i_refresh_ack))
    else begin
        $display("[FAIL] %s: refresh request rose while the ack was still high", test_name);
        proto_errs++;
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n) rsp_mode |-> !o_timeout_err)
    else begin
        $display("[FAIL] %s: timeout_err expected=0 actual=%b", test_name, o_timeout_err);
        value_errs++;
    end

    // one-wire side: delayed ack, response pulse once the request drops
    initial begin
        int delay;
        i_refresh_ack = 1'b0;
        i_rsp         = 1'b0;
        forever begin
            @(posedge i_clk);
            if (o_refresh_req && !i_refresh_ack) begin
                delay = int'($urandom_range(1, 8));
                repeat (delay - 1) @(posedge i_clk);
                i_refresh_ack <= 1'b1;
                refresh_count++;
                do @(posedge i_clk); while (o_refresh_req);
                if (rsp_mode) begin
                    i_rsp <= 1'b1;
                end
                @(posedge i_clk);
                i_rsp <= 1'b0;
                // every third ack outlasts a whole refresh period
                if (refresh_count % 3 == 0) begin
                    repeat (ACK_HOLD_CYC) @(posedge i_clk);
                end
                i_refresh_ack <= 1'b0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge i_clk);
        $display("watchdog expired, the tests did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int target;
        void'($urandom(83268));
        i_rst_n       = 1'b0;
        i_scan_en     = 1'b0;
        i_link_en     = 1'b0;
        i_wr_en       = 1'b0;
        i_wr_addr     = '0;
        i_wr_data     = '0;
        i_wr_crc      = '0;
        i_spi_wdg_rst = 1'b0;
        for (int i = 0; i < SCAN_REG_NUM; i++) reg_bad[i] = 1'b0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        i_scan_en <= 1'b1;

        test_name = "clean_scan";
        wait_reads(8);
        check_flags();
        for (int i = 0; i < SCAN_REG_NUM - 1; i++) write_reg(i, 8'($urandom_range(0, 255)), 1'b1);
        write_reg(SCAN_REG_NUM - 1, cfg_word(P250, P250, P250), 1'b1);
        wait_reads(8);
        check_flags();

        test_name = "corrupt_crc";
        write_reg(1, 8'($urandom_range(0, 255)), 1'b0);
        write_reg(4, 8'($urandom_range(0, 255)), 1'b0);
        wait_reads(8);
        check_flags();
        write_reg(1, 8'($urandom_range(0, 255)), 1'b1);
        check_flags();
        wait_reads(8);
        check_flags();

        test_name = "refresh_rsp";
        write_reg(SCAN_REG_NUM - 1, cfg_word(P250, P250, P1000), 1'b1);
        @(posedge i_clk);
        rsp_mode  <= 1'b1;
        i_link_en <= 1'b1;
        target = refresh_count + 6;
        while (refresh_count < target) @(negedge i_clk);

        test_name = "timeout";
        @(posedge i_clk);
        rsp_mode <= 1'b0;
        write_reg(SCAN_REG_NUM - 1, cfg_word(P250, P2000, P250), 1'b1);
        check_timeout(P250);
        write_reg(SCAN_REG_NUM - 1, cfg_word(P250, P2000, P500), 1'b1);
        check_timeout(P500);

        test_name = "disable";
        @(posedge i_clk);
        rsp_mode <= 1'b1;
        write_reg(SCAN_REG_NUM - 1, cfg_word(P250, P250, P500), 1'b1);
        @(negedge i_clk);
        while (!o_refresh_req) @(negedge i_clk);
        @(posedge i_clk);
        i_scan_en <= 1'b0;
        i_link_en <= 1'b0;
        @(posedge i_clk);
        @(negedge i_clk);
        assert (!o_refresh_req) else begin
            $display("[FAIL] %s: refresh_req expected=0 actual=%b", test_name, o_refresh_req);
            value_errs++;
        end
        repeat (2 * int'(PERIOD_UNITS[1]) * CYC) begin
            @(negedge i_clk);
            assert (!dut_i.scan_bus.req && !o_refresh_req && !o_timeout_err) else begin
                $display("[FAIL] %s: idle outputs expected=000 actual=%b%b%b", test_name,
                         dut_i.scan_bus.req, o_refresh_req, o_timeout_err);
                value_errs++;
            end
        end

        $display("errors: value=%0d protocol=%0d", value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
